//--- tracer_params.svh
`ifndef TRACER_PARAMS_SVH
`define TRACER_PARAMS_SVH

// Signed fixed-point format used by every datapath word
// Ten integer bits cover the map and the step distances; ten fraction bits give 1/1024 cells
`define FIX_INT 10
`define FIX_FRAC 10
`define FIX_W (`FIX_INT + `FIX_FRAC)

// The map is 2**MAP_BITS cells on each side
`define MAP_BITS 4

// Deflection of the first traced row, counted in camera plane vectors
// Half the visible height plus the back porch, less one row because results show a row late
`define ROW_START 272

// Hits nearer than one eighth of a cell would overflow the size and are traced past
`define MIN_DIST_FRAC (1 << (`FIX_FRAC - 3))

// Widths of the texture column and of the wall half-size
`define TEXU_BITS 6
`define SIZE_BITS 11

// Cycles from a reciprocal start to its done pulse
`define RCP_CYCLES (`FIX_W + 2)

`endif

//--- fixedPointPkg.sv
`include "tracer_params.svh"

// Word types of the fixed-point datapath
package fixedPointPkg;

  // One signed word with FIX_FRAC fraction bits
  typedef logic signed [`FIX_W-1:0] fixWord_t;

  // Full product of two words
  // Its fraction is twice as wide, so the word-sized result sits FIX_FRAC bits up
  typedef logic signed [2*`FIX_W-1:0] fixProd_t;

  // The two fields of a word, integer part on top
  typedef struct packed {
    logic signed [`FIX_INT-1:0] intPart;
    logic [`FIX_FRAC-1:0]       fracPart;
  } fixParts_s;

  // One word seen two ways
  // For a map position the integer field is the cell index
  // and the fraction field is the offset inside that cell
  typedef union packed {
    fixWord_t  raw;
    fixParts_s parts;
  } fixView_u;

endpackage

//--- tracerPkg.sv
`include "tracer_params.svh"

// Control and interface types of the wall tracer
package tracerPkg;

  // Walker states, in the order one row passes through them
  typedef enum logic [3:0] {
    // Step distance along X, the reciprocal of ray X
    StXStepReq  = 4'd0,
    StXStepWait = 4'd1,
    // Step distance along Y
    StYStepReq  = 4'd2,
    StYStepWait = 4'd3,
    // Initial track distances from the player's offset in the cell
    StTrackX    = 4'd4,
    StTrackY    = 4'd5,
    // Grid walk, one cell per cycle until a hit
    StDdaStep   = 4'd6,
    // Wall size from the reciprocal of the wall distance
    StSizeReq   = 4'd7,
    StSizeWait  = 4'd8,
    // Texture column from the hit point
    StTexU      = 4'd9,
    // Result ready, waiting for the line end
    StDone      = 4'd15
  } traceState_e;

  // Player view for one frame
  typedef struct packed {
    fixedPointPkg::fixWord_t playerX;
    fixedPointPkg::fixWord_t playerY;
    fixedPointPkg::fixWord_t facingX;
    fixedPointPkg::fixWord_t facingY;
    fixedPointPkg::fixWord_t planeX;
    fixedPointPkg::fixWord_t planeY;
  } camera_s;

  // One traced row as shown on the following line
  typedef struct packed {
    logic [1:0]              wallId;
    logic                    side;
    logic [`SIZE_BITS-1:0]   size;
    logic [`TEXU_BITS-1:0]   texU;
    // Perpendicular wall distance, the texture v addend
    fixedPointPkg::fixWord_t texA;
  } rowResult_s;

endpackage

//--- rayStepper.sv
`timescale 1ns/1ps
`include "tracer_params.svh"

// Forms the ray direction of the row being traced
module rayStepper (
  input  logic                    clk,
  input  logic                    do_reset,
  input  logic                    i_vsync,
  input  fixedPointPkg::fixWord_t i_planeX,
  input  fixedPointPkg::fixWord_t i_planeY,
  input  fixedPointPkg::fixWord_t i_facingX,
  input  fixedPointPkg::fixWord_t i_facingY,
  input  logic                    i_rowAdvance,
  output fixedPointPkg::fixWord_t o_rayDirX,
  output fixedPointPkg::fixWord_t o_rayDirY
);

  // Deflection from the facing vector, kept in whole plane vectors per row
  // A fraction of the plane per row would lose too much precision,
  // so the full vector is accumulated and scaled down when the ray is formed
  fixedPointPkg::fixWord_t deflX;
  fixedPointPkg::fixWord_t deflY;

  // Deflection of the top row
  fixedPointPkg::fixWord_t firstDeflX;
  fixedPointPkg::fixWord_t firstDeflY;

  // The constant multiply reduces to two shifted adds
  assign firstDeflX = fixedPointPkg::fixWord_t'(-(i_planeX * `ROW_START));
  assign firstDeflY = fixedPointPkg::fixWord_t'(-(i_planeY * `ROW_START));

  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      // Every frame starts again from the top row
      deflX <= firstDeflX;
      deflY <= firstDeflY;
    end else if (i_rowAdvance) begin
      // One row further down the screen
      deflX <= deflX + i_planeX;
      deflY <= deflY + i_planeY;
    end
  end

  // The shift by 8 brings the accumulated deflection back to plane scale
  // and so sets the field of view
  assign o_rayDirX = i_facingX + (deflX >>> 8);
  assign o_rayDirY = i_facingY + (deflY >>> 8);

endmodule

//--- fixedReciprocal.sv
`timescale 1ns/1ps
`include "tracer_params.svh"

// Sequential reciprocal of the absolute input value
// The quotient 2**(2*FIX_FRAC) / |value| is built one bit per cycle
module fixedReciprocal (
  input  logic                    clk,
  input  logic                    do_reset,
  input  logic                    i_start,
  input  fixedPointPkg::fixWord_t i_value,
  output fixedPointPkg::fixWord_t o_recip,
  output logic                    o_done
);

  // One load cycle, FIX_W quotient bits, then the result cycle
  localparam int LastCount = `RCP_CYCLES - 2;
  localparam int CountBits = $clog2(LastCount + 1);
  localparam logic [CountBits-1:0] LastCountW = LastCount[CountBits-1:0];

  // Dividend bits above the FIX_W that are walked form the first remainder
  localparam logic [`FIX_W:0] InitRem = (`FIX_W + 1)'(1) << (2 * `FIX_FRAC - `FIX_W);

  // Any divisor up to this makes the quotient reach 2**(FIX_W-1)
  // Zero is caught by the same test
  localparam logic [`FIX_W-1:0] SatLimit = `FIX_W'(1) << (2 * `FIX_FRAC - `FIX_W + 1);

  // Largest positive word
  localparam fixedPointPkg::fixWord_t MaxPos = {1'b0, {(`FIX_W-1){1'b1}}};

  logic [`FIX_W-1:0]    absValue;
  logic [`FIX_W-1:0]    divisor;
  logic [`FIX_W:0]      remainder;
  logic [`FIX_W:0]      shiftedRem;
  logic                 fitBit;
  logic [`FIX_W-1:0]    quotient;
  logic                 saturate;
  logic                 busy;
  logic [CountBits-1:0] bitCount;

  // The most negative word maps onto 2**(FIX_W-1), which still fits unsigned
  assign absValue = i_value[`FIX_W-1] ? -i_value : i_value;

  // Remaining dividend bits are all zero, so each step only shifts a zero in
  assign shiftedRem = {remainder[`FIX_W-1:0], 1'b0};
  assign fitBit = shiftedRem >= {1'b0, divisor};

  // Sequencing and the done pulse
  always_ff @(posedge clk) begin
    if (do_reset) begin
      busy     <= 1'b0;
      bitCount <= '0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        // A new start abandons any division in flight
        busy     <= 1'b1;
        bitCount <= '0;
      end else if (busy) begin
        if (bitCount == LastCountW) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end else begin
          bitCount <= bitCount + 1'b1;
        end
      end
    end
  end

  // Restoring division datapath
  always_ff @(posedge clk) begin
    if (i_start) begin
      divisor   <= absValue;
      saturate  <= absValue <= SatLimit;
      remainder <= InitRem;
      quotient  <= '0;
    end else if (busy) begin
      if (bitCount == LastCountW) begin
        // Output stays put until the next division ends
        o_recip <= saturate ? MaxPos : quotient;
      end else begin
        remainder <= fitBit ? shiftedRem - {1'b0, divisor} : shiftedRem;
        quotient  <= {quotient[`FIX_W-2:0], fitBit};
      end
    end
  end

endmodule

//--- gridWalker.sv
`timescale 1ns/1ps
`include "tracer_params.svh"

// Traces one ray per row through the map grid and holds the row result
module gridWalker (
  input  logic                    clk,
  input  logic                    do_reset,
  input  logic                    i_vsync,
  input  logic                    i_hmax,
  input  fixedPointPkg::fixWord_t i_playerX,
  input  fixedPointPkg::fixWord_t i_playerY,
  input  fixedPointPkg::fixWord_t i_rayDirX,
  input  fixedPointPkg::fixWord_t i_rayDirY,
  output logic                    o_rcpStart,
  output fixedPointPkg::fixWord_t o_rcpIn,
  input  fixedPointPkg::fixWord_t i_rcpOut,
  input  logic                    i_rcpDone,
  output logic [`MAP_BITS-1:0]    o_mapCol,
  output logic [`MAP_BITS-1:0]    o_mapRow,
  input  logic [1:0]              i_mapVal,
  output logic                    o_rowAdvance,
  output tracerPkg::rowResult_s   o_result,
  output logic                    o_rowPresent
);

  localparam fixedPointPkg::fixWord_t OneFix = 1 << `FIX_FRAC;
  localparam fixedPointPkg::fixWord_t MinDist = `MIN_DIST_FRAC;

  tracerPkg::traceState_e state;

  // Player position split into cell and offset
  fixedPointPkg::fixView_u posX;
  fixedPointPkg::fixView_u posY;
  fixedPointPkg::fixWord_t fracWordX;
  fixedPointPkg::fixWord_t fracWordY;
  // Part of a cell crossed before the first grid line
  fixedPointPkg::fixWord_t partialX;
  fixedPointPkg::fixWord_t partialY;
  logic                    rayPosX;
  logic                    rayPosY;

  fixedPointPkg::fixWord_t stepDistX;
  fixedPointPkg::fixWord_t stepDistY;
  // Track distances are unsigned so that a saturated step that wraps still compares as far away
  logic [`FIX_W-1:0]       trackDistX;
  logic [`FIX_W-1:0]       trackDistY;
  fixedPointPkg::fixWord_t wallDist;
  logic signed [`FIX_INT-1:0] mapX;
  logic signed [`FIX_INT-1:0] mapY;
  logic                    side;
  logic [1:0]              wallId;
  logic [`SIZE_BITS-1:0]   sizeReg;
  logic [`TEXU_BITS-1:0]   texU;

  // The one multiplier and what is derived from it
  fixedPointPkg::fixWord_t mulA;
  fixedPointPkg::fixWord_t mulB;
  fixedPointPkg::fixProd_t mulOut;
  fixedPointPkg::fixWord_t mulMid;
  fixedPointPkg::fixWord_t wallPartial;
  logic                    texMirror;
  logic                    needStepX;
  logic                    ownCell;
  logic                    isHit;

  assign posX.raw = i_playerX;
  assign posY.raw = i_playerY;
  assign fracWordX = {{`FIX_INT{1'b0}}, posX.parts.fracPart};
  assign fracWordY = {{`FIX_INT{1'b0}}, posY.parts.fracPart};

  assign rayPosX = i_rayDirX > 0;
  assign rayPosY = i_rayDirY > 0;

  // Walking up, the first line is the far edge of the cell; walking down it is the near one
  assign partialX = rayPosX ? OneFix - fracWordX : fracWordX;
  assign partialY = rayPosY ? OneFix - fracWordY : fracWordY;

  // Multiplier operands follow the state that takes the product
  always_comb begin
    case (state)
      tracerPkg::StTrackX: begin
        mulA = stepDistX;
        mulB = partialX;
      end
      tracerPkg::StTrackY: begin
        mulA = stepDistY;
        mulB = partialY;
      end
      default: begin
        // Hit point along the wall, used in StTexU
        mulA = side ? i_rayDirX : i_rayDirY;
        mulB = wallDist;
      end
    endcase
  end

  assign mulOut = mulA * mulB;
  assign mulMid = mulOut[`FIX_W+`FIX_FRAC-1:`FIX_FRAC];

  // Reciprocal source, held from the request until the divider has sampled it
  always_comb begin
    case (state)
      tracerPkg::StXStepReq,
      tracerPkg::StXStepWait: o_rcpIn = i_rayDirX;
      tracerPkg::StYStepReq,
      tracerPkg::StYStepWait: o_rcpIn = i_rayDirY;
      default:                o_rcpIn = wallDist;
    endcase
  end

  assign o_mapCol = mapX[`MAP_BITS-1:0];
  assign o_mapRow = mapY[`MAP_BITS-1:0];

  assign needStepX = trackDistX < trackDistY;
  assign ownCell = (mapX == posX.parts.intPart) && (mapY == posY.parts.intPart);
  assign isHit = (i_mapVal != 2'd0) && (wallDist >= MinDist) && !ownCell;

  // Position along the wall face, its fraction picks the texture column
  assign wallPartial = mulMid + (side ? i_playerX : i_playerY);
  // Faces seen from the far side would show the texture mirrored
  assign texMirror = side ? rayPosY : ~rayPosX;

  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      state        <= tracerPkg::StXStepReq;
      o_rcpStart   <= 1'b0;
      o_rowAdvance <= 1'b0;
      o_rowPresent <= 1'b0;
      o_result     <= '0;
    end else begin
      o_rcpStart   <= 1'b0;
      o_rowAdvance <= 1'b0;
      o_rowPresent <= 1'b0;
      case (state)
        tracerPkg::StXStepReq: begin
          // Start lands a cycle later, after the stepper has taken the new row
          o_rcpStart <= 1'b1;
          state      <= tracerPkg::StXStepWait;
        end
        tracerPkg::StXStepWait: begin
          if (i_rcpDone) begin
            stepDistX <= i_rcpOut;
            state     <= tracerPkg::StYStepReq;
          end
        end
        tracerPkg::StYStepReq: begin
          o_rcpStart <= 1'b1;
          state      <= tracerPkg::StYStepWait;
        end
        tracerPkg::StYStepWait: begin
          if (i_rcpDone) begin
            stepDistY <= i_rcpOut;
            state     <= tracerPkg::StTrackX;
          end
        end
        tracerPkg::StTrackX: begin
          trackDistX <= mulMid;
          // The walk begins in the player's own cell
          mapX       <= posX.parts.intPart;
          mapY       <= posY.parts.intPart;
          state      <= tracerPkg::StTrackY;
        end
        tracerPkg::StTrackY: begin
          trackDistY <= mulMid;
          state      <= tracerPkg::StDdaStep;
        end
        tracerPkg::StDdaStep: begin
          if (isHit) begin
            wallId <= i_mapVal;
            state  <= tracerPkg::StSizeReq;
          end else if (needStepX) begin
            // Cross the nearer grid line
            mapX       <= rayPosX ? mapX + 1'b1 : mapX - 1'b1;
            trackDistX <= trackDistX + stepDistX;
            wallDist   <= trackDistX;
            side       <= 1'b0;
          end else begin
            mapY       <= rayPosY ? mapY + 1'b1 : mapY - 1'b1;
            trackDistY <= trackDistY + stepDistY;
            wallDist   <= trackDistY;
            side       <= 1'b1;
          end
        end
        tracerPkg::StSizeReq: begin
          o_rcpStart <= 1'b1;
          state      <= tracerPkg::StSizeWait;
        end
        tracerPkg::StSizeWait: begin
          if (i_rcpDone) begin
            // 256 / distance, so a wall one cell away is 256 rows half-high
            sizeReg <= i_rcpOut[`FIX_FRAC-8 +: `SIZE_BITS];
            state   <= tracerPkg::StTexU;
          end
        end
        tracerPkg::StTexU: begin
          texU  <= wallPartial[`FIX_FRAC-1 -: `TEXU_BITS] ^ {`TEXU_BITS{texMirror}};
          state <= tracerPkg::StDone;
        end
        tracerPkg::StDone: begin
          // The line end is the only way out, anything earlier is ignored
          if (i_hmax) begin
            o_result.wallId <= wallId;
            o_result.side   <= side;
            o_result.size   <= sizeReg;
            o_result.texU   <= texU;
            o_result.texA   <= wallDist;
            o_rowPresent    <= 1'b1;
            o_rowAdvance    <= 1'b1;
            state           <= tracerPkg::StXStepReq;
          end
        end
        default: begin
          state <= tracerPkg::StXStepReq;
        end
      endcase
    end
  end

endmodule

//--- wallTracer.sv
`timescale 1ns/1ps
`include "tracer_params.svh"

// Row-by-row wall tracer
// The ray stepper aims each row, the walker traces it with the shared divider
module wallTracer (
  input  logic                  clk,
  input  logic                  do_reset,
  input  logic                  i_vsync,
  input  logic                  i_hmax,
  input  tracerPkg::camera_s    i_camera,
  input  logic [1:0]            i_mapVal,
  output logic [`MAP_BITS-1:0]  o_mapCol,
  output logic [`MAP_BITS-1:0]  o_mapRow,
  output tracerPkg::rowResult_s o_result,
  output logic                  o_rowPresent
);

  fixedPointPkg::fixWord_t rayDirX;
  fixedPointPkg::fixWord_t rayDirY;
  logic                    rowAdvance;
  logic                    rcpStart;
  fixedPointPkg::fixWord_t rcpIn;
  fixedPointPkg::fixWord_t rcpOut;
  logic                    rcpDone;
  logic                    divReset;

  // A division left over from before vsync must not end inside the new frame
  assign divReset = do_reset || i_vsync;

  rayStepper stepper (
    .clk          (clk),
    .do_reset     (do_reset),
    .i_vsync      (i_vsync),
    .i_planeX     (i_camera.planeX),
    .i_planeY     (i_camera.planeY),
    .i_facingX    (i_camera.facingX),
    .i_facingY    (i_camera.facingY),
    .i_rowAdvance (rowAdvance),
    .o_rayDirX    (rayDirX),
    .o_rayDirY    (rayDirY)
  );

  fixedReciprocal reciprocal (
    .clk      (clk),
    .do_reset (divReset),
    .i_start  (rcpStart),
    .i_value  (rcpIn),
    .o_recip  (rcpOut),
    .o_done   (rcpDone)
  );

  gridWalker walker (
    .clk          (clk),
    .do_reset     (do_reset),
    .i_vsync      (i_vsync),
    .i_hmax       (i_hmax),
    .i_playerX    (i_camera.playerX),
    .i_playerY    (i_camera.playerY),
    .i_rayDirX    (rayDirX),
    .i_rayDirY    (rayDirY),
    .o_rcpStart   (rcpStart),
    .o_rcpIn      (rcpIn),
    .i_rcpOut     (rcpOut),
    .i_rcpDone    (rcpDone),
    .o_mapCol     (o_mapCol),
    .o_mapRow     (o_mapRow),
    .i_mapVal     (i_mapVal),
    .o_rowAdvance (rowAdvance),
    .o_result     (o_result),
    .o_rowPresent (o_rowPresent)
  );

endmodule

//--- wallTracer_sva.sv
`timescale 1ns/1ps
`include "tracer_params.svh"

// Protocol properties of the tracer outputs
module wallTracerSva (
  input logic                  clk,
  input logic                  do_reset,
  input logic                  i_vsync,
  input logic                  i_hmax,
  input logic                  i_rowPresent,
  input tracerPkg::rowResult_s i_result
);

  // A row is shown only in answer to the line end one cycle before
  rowAfterLineEnd: assert property (
    @(posedge clk) disable iff (do_reset) i_rowPresent |-> $past(i_hmax)
  ) else $error("row strobe without a line end in the previous cycle");

  // Vsync holds the tracer quiet
  noRowInVsync: assert property (
    @(posedge clk) i_vsync |-> !i_rowPresent
  ) else $error("row strobe while vsync is high");

  // Reset and vsync clear the result register
  resultClearedByReset: assert property (
    @(posedge clk) (do_reset || i_vsync) |=> (i_result == '0)
  ) else $error("result not cleared by reset");

endmodule

bind wallTracer wallTracerSva rules (
  .clk          (clk),
  .do_reset     (do_reset),
  .i_vsync      (i_vsync),
  .i_hmax       (i_hmax),
  .i_rowPresent (o_rowPresent),
  .i_result     (o_result)
);

//--- tb_wallTracer.sv
`timescale 1ns/1ps
`include "tracer_params.svh"

// Testbench for the row-by-row wall tracer
module tb_wallTracer;

  localparam int RandomFrames = 3;
  localparam int RowsPerFrame = 40;
  localparam int MinGap = 150;
  localparam int MaxGap = 400;
  localparam int SlowRows = 6;
  localparam int SlowGap = 1000;
  localparam int RestartRows = 18;
  localparam int WallRows = 20;
  // Every line end spaced at its longest, plus room for the vsync gaps and the tail
  localparam int TimeoutCycles = (RandomFrames * RowsPerFrame + RestartRows + WallRows) * MaxGap
                                 + SlowRows * SlowGap + 4000;
  localparam int MapSide = 1 << `MAP_BITS;
  localparam int MinDist = `MIN_DIST_FRAC;
  localparam int MaxWalkSteps = 64;
  localparam longint MaxPos = (longint'(1) << (`FIX_W - 1)) - 1;

  logic clk = 1'b0;
  logic do_reset;
  logic i_vsync;
  logic i_hmax;
  tracerPkg::camera_s camera;
  logic [1:0] mapVal;
  logic [`MAP_BITS-1:0] mapCol;
  logic [`MAP_BITS-1:0] mapRow;
  tracerPkg::rowResult_s result;
  logic rowPresent;

  // Map ROM, one wall ID per cell, addressed as row then column
  logic [1:0] mapRom [0:MapSide*MapSide-1];

  int errorCount = 0;
  int checkCount = 0;
  int rowIdx = 0;
  int cycleCount = 0;
  // Set once the first clock edge has gone by
  logic edgeSeen = 1'b0;
  // Reset and line end as the DUT saw them one edge earlier
  logic resetSeen = 1'b1;
  logic hmaxSeen = 1'b0;

  always #10 clk = ~clk;

  wallTracer uut (
    .clk          (clk),
    .do_reset     (do_reset),
    .i_vsync      (i_vsync),
    .i_hmax       (i_hmax),
    .i_camera     (camera),
    .i_mapVal     (mapVal),
    .o_mapCol     (mapCol),
    .o_mapRow     (mapRow),
    .o_result     (result),
    .o_rowPresent (rowPresent)
  );

  // The ROM answers in the same cycle as the address
  assign mapVal = mapRom[{mapRow, mapCol}];

  task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] want);
    checkCount++;
    if (got !== want) begin
      errorCount++;
      $display("Mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, want);
    end
  endtask

  // 2**(2*FIX_FRAC) over the magnitude, largest positive word on zero or overflow
  function automatic logic signed [`FIX_W-1:0] recipRef(input logic signed [`FIX_W-1:0] value);
    logic [`FIX_W-1:0] mag;
    longint quot;
    mag = (value < 0) ? -value : value;
    if (mag == 0) return MaxPos[`FIX_W-1:0];
    quot = (longint'(1) << (2 * `FIX_FRAC)) / longint'(mag);
    if (quot > MaxPos) return MaxPos[`FIX_W-1:0];
    return quot[`FIX_W-1:0];
  endfunction

  // Expected result of one row, traced with the fixed-point rules of the tracer
  function automatic tracerPkg::rowResult_s refTraceRow(input int row,
                                                        input tracerPkg::camera_s cam);
    tracerPkg::rowResult_s res;
    logic signed [`FIX_W-1:0] deflX, deflY, rayX, rayY, stepX, stepY, wallDist, hitPos, recip;
    logic [`FIX_W-1:0] trackX, trackY, partX, partY;
    logic signed [2*`FIX_W-1:0] prod;
    logic signed [`FIX_INT-1:0] ownX, ownY, cellX, cellY;
    logic [`TEXU_BITS-1:0] texBits;
    logic [1:0] cellVal;
    logic side, hit, mirror;
    int fracX, fracY, step;
    // Row n sees the plane vector n - ROW_START times, scaled down by 256
    deflX = `FIX_W'((row - `ROW_START) * int'($signed(cam.planeX)));
    deflY = `FIX_W'((row - `ROW_START) * int'($signed(cam.planeY)));
    rayX = $signed(cam.facingX) + (deflX >>> 8);
    rayY = $signed(cam.facingY) + (deflY >>> 8);
    stepX = recipRef(rayX);
    stepY = recipRef(rayY);
    ownX = cam.playerX[`FIX_W-1:`FIX_FRAC];
    ownY = cam.playerY[`FIX_W-1:`FIX_FRAC];
    fracX = cam.playerX[`FIX_FRAC-1:0];
    fracY = cam.playerY[`FIX_FRAC-1:0];
    // Distance to the first grid line on each axis
    partX = (rayX > 0) ? `FIX_W'((1 << `FIX_FRAC) - fracX) : `FIX_W'(fracX);
    partY = (rayY > 0) ? `FIX_W'((1 << `FIX_FRAC) - fracY) : `FIX_W'(fracY);
    prod = stepX * $signed(partX);
    trackX = prod[`FIX_W+`FIX_FRAC-1:`FIX_FRAC];
    prod = stepY * $signed(partY);
    trackY = prod[`FIX_W+`FIX_FRAC-1:`FIX_FRAC];
    cellX = ownX;
    cellY = ownY;
    wallDist = '0;
    side = 1'b0;
    hit = 1'b0;
    cellVal = 2'd0;
    for (step = 0; step < MaxWalkSteps && !hit; step++) begin
      if (trackX < trackY) begin
        cellX = (rayX > 0) ? cellX + 1 : cellX - 1;
        wallDist = trackX;
        trackX = trackX + stepX;
        side = 1'b0;
      end else begin
        cellY = (rayY > 0) ? cellY + 1 : cellY - 1;
        wallDist = trackY;
        trackY = trackY + stepY;
        side = 1'b1;
      end
      cellVal = mapRom[{cellY[`MAP_BITS-1:0], cellX[`MAP_BITS-1:0]}];
      hit = (cellVal != 2'd0) && (wallDist >= MinDist) && !((cellX == ownX) && (cellY == ownY));
    end
    recip = recipRef(wallDist);
    // 256 rows for a wall one cell away
    res.size = `SIZE_BITS'(recip >>> 2);
    prod = (side ? rayX : rayY) * wallDist;
    hitPos = prod[`FIX_W+`FIX_FRAC-1:`FIX_FRAC] + (side ? $signed(cam.playerX) : $signed(cam.playerY));
    texBits = hitPos[`FIX_FRAC-1 -: `TEXU_BITS];
    mirror = side ? (rayY > 0) : !(rayX > 0);
    res.texU = mirror ? ~texBits : texBits;
    res.wallId = cellVal;
    res.side = side;
    res.texA = wallDist;
    return res;
  endfunction

  // Closed border, random interior walls
  task automatic fillMap(input int wallPercent);
    int r, c;
    for (r = 0; r < MapSide; r++) begin
      for (c = 0; c < MapSide; c++) begin
        if (r == 0 || r == MapSide - 1 || c == 0 || c == MapSide - 1)
          mapRom[r*MapSide+c] <= 2'(1 + (r + c) % 3);
        else if (($urandom % 100) < wallPercent)
          mapRom[r*MapSide+c] <= 2'(1 + $urandom % 3);
        else
          mapRom[r*MapSide+c] <= 2'd0;
      end
    end
  endtask

  function automatic tracerPkg::camera_s randomCamera();
    tracerPkg::camera_s cam;
    int fx, fy;
    // Player stays at least a cell clear of the border
    cam.playerX = `FIX_W'(((2 + $urandom % 12) << `FIX_FRAC) + $urandom % 1024);
    cam.playerY = `FIX_W'(((2 + $urandom % 12) << `FIX_FRAC) + $urandom % 1024);
    fx = int'($urandom % 2049) - 1024;
    fy = int'($urandom % 2049) - 1024;
    if (fx * fx + fy * fy < 250000) fx = (fx < 0) ? -1024 : 1024;
    cam.facingX = `FIX_W'(fx);
    cam.facingY = `FIX_W'(fy);
    cam.planeX = `FIX_W'(int'($urandom % 1201) - 600);
    cam.planeY = `FIX_W'(int'($urandom % 1201) - 600);
    return cam;
  endfunction

  function automatic tracerPkg::camera_s fixedCamera(input int px, input int py, input int fx,
                                                      input int fy, input int qx, input int qy);
    tracerPkg::camera_s cam;
    cam.playerX = `FIX_W'(px);
    cam.playerY = `FIX_W'(py);
    cam.facingX = `FIX_W'(fx);
    cam.facingY = `FIX_W'(fy);
    cam.planeX = `FIX_W'(qx);
    cam.planeY = `FIX_W'(qy);
    return cam;
  endfunction

  task automatic enterVsync();
    repeat (20) @(posedge clk);
    i_vsync <= 1'b1;
    repeat (4) @(posedge clk);
  endtask

  task automatic leaveVsync();
    @(posedge clk);
    i_vsync <= 1'b0;
  endtask

  // Line ends at random spacing, each one cycle long
  task automatic sendRows(input int count, input int gapLo, input int gapHi);
    int n, gap;
    for (n = 0; n < count; n++) begin
      gap = gapLo + int'($urandom % (gapHi - gapLo + 1));
      repeat (gap) @(posedge clk);
      i_hmax <= 1'b1;
      @(posedge clk);
      i_hmax <= 1'b0;
    end
  endtask

  // Compare process, every output sampled at the clock edge
  always @(posedge clk) begin
    tracerPkg::rowResult_s refRow;
    edgeSeen <= 1'b1;
    resetSeen <= do_reset || i_vsync;
    hmaxSeen <= i_hmax;
    if (!edgeSeen) begin
      // The DUT has not seen a reset edge yet
      rowIdx <= 0;
    end else if (resetSeen) begin
      rowIdx <= 0;
      checkValue("result held in reset", result, '0);
      checkValue("row strobe in reset", rowPresent, 1'b0);
    end else begin
      // One row per line end and none without it
      checkValue("row strobe against line end", rowPresent, hmaxSeen);
      if (rowPresent) begin
        refRow = refTraceRow(rowIdx, camera);
        checkValue($sformatf("row %0d wall ID", rowIdx), result.wallId, refRow.wallId);
        checkValue($sformatf("row %0d side", rowIdx), result.side, refRow.side);
        checkValue($sformatf("row %0d size", rowIdx), result.size, refRow.size);
        checkValue($sformatf("row %0d texU", rowIdx), result.texU, refRow.texU);
        checkValue($sformatf("row %0d texA", rowIdx), result.texA, refRow.texA);
        checkValue($sformatf("row %0d hit inside minimum distance", rowIdx),
                   $signed(result.texA) >= MinDist, 1'b1);
        rowIdx <= rowIdx + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    int frame;
    void'($urandom(32'hff71f5e2));
    do_reset = 1'b1;
    i_vsync = 1'b0;
    i_hmax = 1'b0;
    camera = randomCamera();
    fillMap(20);
    repeat (8) @(posedge clk);
    do_reset <= 1'b0;
    // The first frame starts from reset, the others from vsync
    for (frame = 0; frame < RandomFrames; frame++) begin
      if (frame > 0) begin
        enterVsync();
        fillMap(20);
        camera <= randomCamera();
        leaveVsync();
      end
      sendRows(RowsPerFrame, MinGap, MaxGap);
    end
    // Line ends long after the trace is done
    enterVsync();
    camera <= randomCamera();
    leaveVsync();
    sendRows(SlowRows, SlowGap - 100, SlowGap);
    // Vsync in the middle of a trace restarts at row 0
    enterVsync();
    camera <= randomCamera();
    leaveVsync();
    sendRows(12, MinGap, MaxGap);
    enterVsync();
    leaveVsync();
    sendRows(RestartRows - 12, MinGap, MaxGap);
    // Wall one fortieth of a cell ahead of the player, too near to count
    enterVsync();
    fillMap(0);
    mapRom[7*MapSide+8] <= 2'd2;
    camera <= fixedCamera((7 << 10) + 1000, (7 << 10) + 512, 1024, 0, 0, 600);
    leaveVsync();
    sendRows(WallRows / 2, MinGap, MaxGap);
    // Player standing inside a wall cell with another wall beside it
    enterVsync();
    fillMap(0);
    mapRom[5*MapSide+5] <= 2'd3;
    mapRom[5*MapSide+4] <= 2'd1;
    camera <= fixedCamera((5 << 10) + 512, (5 << 10) + 512, -1024, 300, 200, 500);
    leaveVsync();
    sendRows(WallRows / 2, MinGap, MaxGap);
    repeat (20) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
fixedPointPkg.sv
tracerPkg.sv
rayStepper.sv
fixedReciprocal.sv
gridWalker.sv
wallTracer.sv
wallTracer_sva.sv
tb_wallTracer.sv

//--- run.sh
#!/bin/sh
# Builds the wall tracer testbench with Verilator and runs it.
# The result is decided by searching the simulation log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_wallTracer -f sim.f \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_wallTracer > sim.log 2>&1 \
  || echo "Simulation FAILED: simulator exited with an error" >> sim.log
grep -q "Simulation FAILED" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "FAIL, no result in sim.log"; exit 1; }
echo "PASS"
